// ==== Makefile ====
TOP := mul_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f
	out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== sim.f ====
src/mul_cfg_pkg.sv
src/mul_types_pkg.sv
src/credit_fifo.sv
src/mul_issue.sv
src/nibble_multiplier.sv
src/mul_retire.sv
src/mul_unit_top.sv
tb/mul_unit_tb.sv

// ==== src/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Wrap at DEPTH, so depths need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1))
      nxt = '0;
    else
      nxt = ptr + 1'b1;
    return nxt;
  endfunction

  // Storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry, read without a register stage
  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(DEPTH));

  // A push into a full FIFO means the sender overspent its credits
  a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

  // Reader must only pop a present entry
  a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

// ==== src/mul_cfg_pkg.sv ====
`default_nettype none

package mul_cfg_pkg;

  // Operand width and width of the returned low product
  localparam int WORD_WIDTH = 32;

  // Factor width of each partial product
  localparam int NIBBLE_WIDTH = 4;

  // Request identifier, returned unchanged with the result
  localparam int TAG_WIDTH = 4;

  // Cycles from op_valid into the multiplier to res_valid
  localparam int MUL_LATENCY = 3;

  // Nibbles per operand
  localparam int NIBBLE_COUNT = WORD_WIDTH / NIBBLE_WIDTH;

  // Full product before truncation, upper half feeds overflow
  localparam int PRODUCT_WIDTH = 2 * WORD_WIDTH;

endpackage

`default_nettype wire

// ==== src/mul_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_issue #(
  parameter int IN_DEPTH  = 4,
  parameter int OUT_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  input  mul_types_pkg::mul_req_t req,
  output logic                    req_credit,
  input  logic                    slot_free,
  output logic                    op_valid,
  output mul_types_pkg::mul_req_t op
);

  import mul_types_pkg::*;

  localparam int SLOT_W = $clog2(OUT_DEPTH + 1);

  logic              fifo_empty;
  logic [SLOT_W-1:0] slots;

  // Request buffer, sized to the producer's initial credits
  credit_fifo #(
    .DEPTH     (IN_DEPTH),
    .payload_t (mul_req_t)
  ) u_req_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (req_valid),
    .push_data (req),
    .pop       (op_valid),
    .pop_data  (op),
    .empty     (fifo_empty),
    .full      ()
  );

  // Issue only with a retire slot reserved, the multiplier never stalls
  assign op_valid   = !fifo_empty && (slots != '0);
  // Every pop frees one input entry, so one credit goes back
  assign req_credit = op_valid;

  // Free retire slots: issue takes one, slot_free returns one
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      slots <= SLOT_W'(OUT_DEPTH);
    else
    begin
      case ({op_valid, slot_free})
        2'b10:   slots <= slots - 1'b1;
        2'b01:   slots <= slots + 1'b1;
        default: slots <= slots;
      endcase
    end
  end

  // Retire side never frees more slots than it holds
  a_slots_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    slots <= SLOT_W'(OUT_DEPTH));

endmodule

`default_nettype wire

// ==== src/mul_retire.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_retire #(
  parameter int OUT_DEPTH        = 4,
  parameter int CONSUMER_CREDITS = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    res_valid,
  input  mul_types_pkg::mul_rsp_t res,
  output logic                    slot_free,
  output logic                    rsp_valid,
  output mul_types_pkg::mul_rsp_t rsp,
  input  logic                    rsp_credit
);

  import mul_types_pkg::*;

  localparam int CRED_W = $clog2(CONSUMER_CREDITS + 1);

  logic              fifo_empty;
  logic [CRED_W-1:0] credits;

  // Result buffer, one entry per reservable slot
  credit_fifo #(
    .DEPTH     (OUT_DEPTH),
    .payload_t (mul_rsp_t)
  ) u_rsp_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_valid),
    .push_data (res),
    .pop       (rsp_valid),
    .pop_data  (rsp),
    .empty     (fifo_empty),
    .full      ()
  );

  // Present the head only when the consumer has room for it
  assign rsp_valid = !fifo_empty && (credits != '0);
  // Leaving entry frees a slot for the issue side
  assign slot_free = rsp_valid;

  // Consumer credits: spent on present, returned by rsp_credit
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      credits <= CRED_W'(CONSUMER_CREDITS);
    else
    begin
      case ({rsp_valid, rsp_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Consumer never returns more credits than it was given
  a_credits_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CRED_W'(CONSUMER_CREDITS));

endmodule

`default_nettype wire

// ==== src/mul_types_pkg.sv ====
`default_nettype none

package mul_types_pkg;

  import mul_cfg_pkg::*;

  // Request identifier
  typedef logic [TAG_WIDTH-1:0] tag_t;

  // Operand pair from the producer
  typedef struct packed {
    logic [WORD_WIDTH-1:0] multiplicand;
    logic [WORD_WIDTH-1:0] multiplier;
    tag_t                  tag;
  } mul_req_t;

  // Result towards the consumer
  // Overflow set when any upper product bit is one
  typedef struct packed {
    logic [WORD_WIDTH-1:0] result;
    logic                  overflow;
    tag_t                  tag;
  } mul_rsp_t;

endpackage

`default_nettype wire

// ==== src/mul_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit_top #(
  parameter int IN_DEPTH         = 4,
  parameter int OUT_DEPTH        = 4,
  parameter int CONSUMER_CREDITS = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  input  mul_types_pkg::mul_req_t req,
  output logic                    req_credit,
  output logic                    rsp_valid,
  output mul_types_pkg::mul_rsp_t rsp,
  input  logic                    rsp_credit
);

  import mul_types_pkg::*;

  logic     op_valid;
  mul_req_t op;
  logic     res_valid;
  mul_rsp_t res;
  logic     slot_free;

  // Input side, holds requests until a retire slot is reserved
  mul_issue #(
    .IN_DEPTH  (IN_DEPTH),
    .OUT_DEPTH (OUT_DEPTH)
  ) u_issue (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .slot_free  (slot_free),
    .op_valid   (op_valid),
    .op         (op)
  );

  // Fixed-latency datapath
  nibble_multiplier u_mult (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_valid  (op_valid),
    .op        (op),
    .res_valid (res_valid),
    .res       (res)
  );

  // Output side, in-order results paced by consumer credits
  mul_retire #(
    .OUT_DEPTH        (OUT_DEPTH),
    .CONSUMER_CREDITS (CONSUMER_CREDITS)
  ) u_retire (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_valid  (res_valid),
    .res        (res),
    .slot_free  (slot_free),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

endmodule

`default_nettype wire

// ==== src/nibble_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_multiplier (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    op_valid,
  input  mul_types_pkg::mul_req_t op,
  output logic                    res_valid,
  output mul_types_pkg::mul_rsp_t res
);

  import mul_cfg_pkg::*;
  import mul_types_pkg::*;

  localparam int PW    = PRODUCT_WIDTH;
  // 64 nibble pair products
  localparam int TERMS = NIBBLE_COUNT * NIBBLE_COUNT;
  // Width of the row registered after stage 1
  localparam int ROW1  = TERMS / 2;
  // Stage 2 halves twice more
  localparam int ROW2  = ROW1 / 4;

  logic [PW-1:0] pp       [TERMS];
  logic [PW-1:0] row1_d   [ROW1];
  logic [PW-1:0] s1_row   [ROW1];
  logic [PW-1:0] half_row [ROW1/2];
  logic [PW-1:0] row2_d   [ROW2];
  logic [PW-1:0] s2_row   [ROW2];
  logic [PW-1:0] quad     [ROW2/2];
  logic [PW-1:0] pair     [ROW2/4];
  logic [PW-1:0] full_prod;

  logic s1_valid;
  logic s2_valid;
  tag_t s1_tag;
  tag_t s2_tag;

  // Stage 1: every nibble pair, shifted to its weight, then pairs summed
  always_comb
  begin
    for (int i = 0; i < NIBBLE_COUNT; i++)
    begin
      for (int j = 0; j < NIBBLE_COUNT; j++)
      begin
        pp[i*NIBBLE_COUNT + j] =
          (PW'(op.multiplicand[i*NIBBLE_WIDTH +: NIBBLE_WIDTH]) *
           PW'(op.multiplier[j*NIBBLE_WIDTH +: NIBBLE_WIDTH])) << ((i + j) * NIBBLE_WIDTH);
      end
    end
    for (int k = 0; k < ROW1; k++)
      row1_d[k] = pp[2*k] + pp[2*k + 1];
  end

  // Stage 2: 32 terms down to 8
  always_comb
  begin
    for (int k = 0; k < ROW1/2; k++)
      half_row[k] = s1_row[2*k] + s1_row[2*k + 1];
    for (int k = 0; k < ROW2; k++)
      row2_d[k] = half_row[2*k] + half_row[2*k + 1];
  end

  // Stage 3: 8 terms down to the full product
  always_comb
  begin
    for (int k = 0; k < ROW2/2; k++)
      quad[k] = s2_row[2*k] + s2_row[2*k + 1];
    for (int k = 0; k < ROW2/4; k++)
      pair[k] = quad[2*k] + quad[2*k + 1];
    full_prod = pair[0] + pair[1];
  end

  // Valid chain, one bit per stage
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      res_valid <= 1'b0;
    end
    else
    begin
      s1_valid  <= op_valid;
      s2_valid  <= s1_valid;
      res_valid <= s2_valid;
    end
  end

  // Data and tag, loaded only behind a valid
  always_ff @(posedge clk)
  begin
    if (op_valid)
    begin
      s1_row <= row1_d;
      s1_tag <= op.tag;
    end
    if (s1_valid)
    begin
      s2_row <= row2_d;
      s2_tag <= s1_tag;
    end
    if (s2_valid)
    begin
      res.result   <= full_prod[WORD_WIDTH-1:0];
      // Any upper bit set means the low word lost information
      res.overflow <= |full_prod[PW-1:WORD_WIDTH];
      res.tag      <= s2_tag;
    end
  end

endmodule

`default_nettype wire

// ==== tb/mul_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb;

  import mul_cfg_pkg::*;
  import mul_types_pkg::*;

  localparam int IN_DEPTH         = 4;
  localparam int OUT_DEPTH        = 4;
  localparam int CONSUMER_CREDITS = 2;
  // Roughly eight times the length of ~200 operations under back-pressure
  localparam int TIMEOUT_CYCLES   = 4000;

  logic     clk;
  logic     rst_n;
  logic     rst_q;
  logic     req_valid;
  mul_req_t req;
  logic     req_credit;
  logic     rsp_valid;
  mul_rsp_t rsp;
  logic     rsp_credit;

  // Reference model state
  mul_rsp_t ref_q [$];
  mul_rsp_t exp_head;
  logic     ref_empty;
  tag_t     next_tag;
  integer   seed;
  int       prod_credits;
  int       cons_credits;
  int       accepted;
  int       credit_pulses;
  int       owed;
  int       hold;
  int       stall;
  logic     slow;
  int       cycles;

  mul_unit_top #(
    .IN_DEPTH         (IN_DEPTH),
    .OUT_DEPTH        (OUT_DEPTH),
    .CONSUMER_CREDITS (CONSUMER_CREDITS)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  always #2 clk = ~clk;

  // One cycle delayed reset, marks the first cycle after release
  always @(posedge clk)
    rst_q <= rst_n;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
      abort_run("Timeout: the unit did not finish the operations in time");
  end

  // Full 64-bit product, low word kept, upper word only feeds overflow
  function automatic mul_rsp_t expect_of(input logic [WORD_WIDTH-1:0] a,
                                         input logic [WORD_WIDTH-1:0] b,
                                         input tag_t t);
    logic [2*WORD_WIDTH-1:0] full;
    mul_rsp_t r;
    full       = (2*WORD_WIDTH)'(a) * (2*WORD_WIDTH)'(b);
    r.result   = full[WORD_WIDTH-1:0];
    r.overflow = |full[2*WORD_WIDTH-1:WORD_WIDTH];
    r.tag      = t;
    return r;
  endfunction

  task automatic refresh_head();
    ref_empty = (ref_q.size() == 0);
    if (!ref_empty)
      exp_head = ref_q[0];
  endtask

  // Outputs are read at the falling edge, where they hold the values of the next rising edge
  task automatic advance();
    logic took;
    logic cred;
    @(negedge clk);
    took = rsp_valid;
    cred = req_credit;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    if (cred)
    begin
      prod_credits++;
      credit_pulses++;
    end
    // Credit pulse of the last cycle counted by the DUT at this edge
    if (rsp_credit)
      cons_credits++;
    rsp_credit = 1'b0;
    if (took)
    begin
      void'(ref_q.pop_front());
      cons_credits--;
      owed++;
    end
    // Consumer frees its entries now, later, or not at all during a stall
    if (stall > 0)
      stall--;
    else if (owed > 0)
    begin
      if (hold == 0)
      begin
        rsp_credit = 1'b1;
        owed--;
        if (slow)
          hold = {$random(seed)} % 12;
      end
      else
        hold--;
    end
    refresh_head();
  endtask

  // Waits for a producer credit, then sends one request
  task automatic send_op(input logic [WORD_WIDTH-1:0] a, input logic [WORD_WIDTH-1:0] b);
    while (prod_credits == 0)
      advance();
    req_valid        = 1'b1;
    req.multiplicand = a;
    req.multiplier   = b;
    req.tag          = next_tag;
    prod_credits--;
    accepted++;
    ref_q.push_back(expect_of(a, b, next_tag));
    refresh_head();
    next_tag = next_tag + 1'b1;
    advance();
  endtask

  task automatic random_ops(input int count);
    logic [WORD_WIDTH-1:0] a;
    logic [WORD_WIDTH-1:0] b;
    for (int i = 0; i < count; i++)
    begin
      a = $random(seed);
      b = $random(seed);
      // Short operands now and then, so some products fit in one word
      if (i % 4 == 0)
        a = a & 32'h0000_ffff;
      if (i % 8 == 0)
        b = b & 32'h0000_ffff;
      send_op(a, b);
    end
  endtask

  // Nothing leaves the unit while in reset or on the first cycle after it
  a_quiet_reset: assert property (@(posedge clk)
    (!rst_n || !rst_q) |-> (!rsp_valid && !req_credit))
    else abort_run("rsp_valid or req_credit asserted during or right after reset");

  a_rsp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> !ref_empty)
    else abort_run("rsp_valid asserted with no request outstanding");

  a_rsp_result: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !ref_empty) |-> rsp.result == exp_head.result)
    else abort_run($sformatf("Mismatch rsp.result: got %h expected %h",
                             $sampled(rsp.result), $sampled(exp_head.result)));

  a_rsp_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !ref_empty) |-> rsp.overflow == exp_head.overflow)
    else abort_run($sformatf("Mismatch rsp.overflow: got %h expected %h",
                             $sampled(rsp.overflow), $sampled(exp_head.overflow)));

  a_rsp_tag: assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !ref_empty) |-> rsp.tag == exp_head.tag)
    else abort_run($sformatf("Mismatch rsp.tag: got %h expected %h",
                             $sampled(rsp.tag), $sampled(exp_head.tag)));

  a_consumer_credit: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> cons_credits > 0)
    else abort_run("rsp_valid asserted while the consumer holds no credits");

  a_producer_bound: assert property (@(posedge clk) disable iff (!rst_n)
    prod_credits <= IN_DEPTH)
    else abort_run($sformatf("Mismatch producer credits: got %h above limit %h",
                             $sampled(prod_credits), IN_DEPTH));

  initial
  begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    rsp_credit    = 1'b0;
    seed          = 32'h3414_fd73;
    next_tag      = '0;
    prod_credits  = IN_DEPTH;
    cons_credits  = CONSUMER_CREDITS;
    accepted      = 0;
    credit_pulses = 0;
    owed          = 0;
    hold          = 0;
    stall         = 0;
    slow          = 1'b0;
    cycles        = 0;
    refresh_head();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Directed products with a consumer that returns credits at once
    send_op(32'h0000_0000, 32'h1234_5678);
    send_op(32'hdead_beef, 32'h0000_0000);
    send_op(32'h0000_0001, 32'hcafe_f00d);
    send_op(32'h0000_ffff, 32'h0000_ffff);
    send_op(32'h0001_0000, 32'h0001_0000);
    send_op(32'hffff_ffff, 32'hffff_ffff);

    // Random operands at full rate
    random_ops(100);

    // Back-pressure: a long stall first, then random credit holds
    stall = 60;
    slow  = 1'b1;
    random_ops(100);

    // Drain every result and let the consumer return what it owes
    while (ref_q.size() != 0 || owed != 0 || stall != 0)
      advance();
    repeat (4) advance();

    assert (credit_pulses == accepted)
      else abort_run($sformatf("Mismatch req_credit pulses: got %h expected %h",
                               credit_pulses, accepted));
    assert (prod_credits == IN_DEPTH)
      else abort_run($sformatf("Mismatch producer credits: got %h expected %h",
                               prod_credits, IN_DEPTH));
    assert (cons_credits == CONSUMER_CREDITS)
      else abort_run($sformatf("Mismatch consumer credits: got %h expected %h",
                               cons_credits, CONSUMER_CREDITS));

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
